// File: dv/compute_core_checker.sv
module compute_core_checker (
  input logic                                 clk,
  input logic                                 rst,
  input logic                                 done,
  input poly_core_pkg::opcode_e               opcode,
  input logic                                 dma_bram_en,
  input logic [poly_core_pkg::dma_be_w-1:0]   dma_bram_byte_wea,
  input logic [poly_core_pkg::dma_addr_w-1:0] dma_bram_abs_addr,
  input logic                                 msg_wea,
  input logic                                 pwm_wea,
  input logic [poly_core_pkg::coeff_w-1:0]    pwm_wr_data
);
  timeunit 1ns;
  timeprecision 1ps;

  logic dma_msg_write;

  // full-word DMA write aimed at the message bank, taken from the raw port
  assign dma_msg_write = dma_bram_en && (&dma_bram_byte_wea) &&
                         (dma_bram_abs_addr[poly_core_pkg::dma_sel_lsb +: poly_core_pkg::dma_sel_w]
                          == 2'd0);

  // reset leaves the core idle
  done_low_after_reset: assert property (@(posedge clk) rst |=> !done)
    else $error("done is high in the cycle after reset");

  // during op_pwm the message bank only listens to the multiplier
  no_dma_write_in_pwm: assert property (
    @(posedge clk) disable iff (rst)
    (opcode == poly_core_pkg::op_pwm && dma_msg_write && !pwm_wea) |-> !msg_wea)
    else $error("a DMA write reached the message bank during op_pwm");

  pwm_result_reduced: assert property (
    @(posedge clk) disable iff (rst)
    pwm_wea |-> (pwm_wr_data < poly_core_pkg::q_mod))
    else $error("the multiplier wrote a value that is not below q_mod");

endmodule

bind compute_core compute_core_checker u_checker (
  .clk               (clk),
  .rst               (rst),
  .done              (done),
  .opcode            (opcode),
  .dma_bram_en       (dma_bram_en),
  .dma_bram_byte_wea (dma_bram_byte_wea),
  .dma_bram_abs_addr (dma_bram_abs_addr),
  .msg_wea           (msg_wea),
  .pwm_wea           (pwm_wea),
  .pwm_wr_data       (pwm_wr_data)
);

// File: dv/compute_core_tb.sv
module compute_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_coeff = poly_core_pkg::n_coeff;

  logic clk;
  logic rst;
  logic [poly_core_pkg::cmd_w-1:0] command_in;
  logic command_we;
  logic dma_bram_en;
  logic [poly_core_pkg::dma_be_w-1:0] dma_bram_byte_wea;
  logic [poly_core_pkg::dma_addr_w-1:0] dma_bram_abs_addr;
  logic [poly_core_pkg::dma_word_w-1:0] dina_dma;
  logic [poly_core_pkg::dma_word_w-1:0] doutb_dma;
  logic done;

  logic [poly_core_pkg::coeff_w-1:0] msg_gold [n_coeff];
  logic [poly_core_pkg::coeff_w-1:0] key_gold [n_coeff];
  logic [poly_core_pkg::coeff_w-1:0] prod_gold [n_coeff];
  // what each polynomial should hold right now
  logic [poly_core_pkg::coeff_w-1:0] msg_model [n_coeff];
  logic [poly_core_pkg::coeff_w-1:0] key_model [n_coeff];
  logic pwm_on;

  tb_clock_gen u_clk_gen (
    .clk (clk)
  );

  compute_core u_compute_core (
    .clk               (clk),
    .rst               (rst),
    .command_in        (command_in),
    .command_we        (command_we),
    .dma_bram_en       (dma_bram_en),
    .dma_bram_byte_wea (dma_bram_byte_wea),
    .dma_bram_abs_addr (dma_bram_abs_addr),
    .dina_dma          (dina_dma),
    .doutb_dma         (doutb_dma),
    .done              (done)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      fail_run("stopping at the first mismatch");
    end
  endtask

  // zero-extended coefficient, unmapped selects read as zero
  function automatic logic [63:0] expected_word(input logic [1:0] sel, input logic [5:0] idx);
    logic [63:0] word;
    word = '0;
    if (sel == 2'd0) begin
      word[poly_core_pkg::coeff_w-1:0] = msg_model[idx];
    end else if (sel == 2'd1) begin
      word[poly_core_pkg::coeff_w-1:0] = key_model[idx];
    end
    return word;
  endfunction

  task automatic load_golden();
    int fd;
    int fields;
    int count;
    string line;
    logic [31:0] m;
    logic [31:0] k;
    logic [31:0] p;
    logic [63:0] ref_prod;
    fd = $fopen("dv/pwm_golden.txt", "r");
    if (fd == 0) begin
      fail_run("could not open dv/pwm_golden.txt");
    end
    count = 0;
    while (!$feof(fd) && count < n_coeff) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h", m, k, p);
        if (fields == 3) begin
          // every golden line must be a plain product mod q
          ref_prod = (64'(m) * 64'(k)) % 64'(poly_core_pkg::q_mod);
          compare($sformatf("golden product line %0d", count), 64'(p), ref_prod);
          msg_gold[count] = m[poly_core_pkg::coeff_w-1:0];
          key_gold[count] = k[poly_core_pkg::coeff_w-1:0];
          prod_gold[count] = p[poly_core_pkg::coeff_w-1:0];
          count++;
        end
      end
    end
    $fclose(fd);
    if (count != n_coeff) begin
      fail_run("the golden file holds fewer coefficient lines than expected");
    end
  endtask

  task automatic dma_access(input logic [1:0] sel, input logic [5:0] idx,
                            input logic [7:0] be, input logic [63:0] data);
    @(posedge clk);
    dma_bram_en <= 1'b1;
    dma_bram_byte_wea <= be;
    // byte offset bits carry noise, the core ignores them
    dma_bram_abs_addr <= {sel, idx, idx[2:0]};
    dina_dma <= data;
    @(posedge clk);
    dma_bram_en <= 1'b0;
    dma_bram_byte_wea <= '0;
    if (be == 8'hff && !pwm_on) begin
      if (sel == 2'd0) begin
        msg_model[idx] = data[poly_core_pkg::coeff_w-1:0];
      end else if (sel == 2'd1) begin
        key_model[idx] = data[poly_core_pkg::coeff_w-1:0];
      end
    end
  endtask

  task automatic read_check(input logic [1:0] sel, input logic [5:0] idx);
    @(posedge clk);
    dma_bram_en <= 1'b1;
    dma_bram_byte_wea <= '0;
    dma_bram_abs_addr <= {sel, idx, 3'b000};
    @(posedge clk);
    dma_bram_en <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    compare($sformatf("doutb_dma (sel %0d, idx %0d)", sel, idx), doutb_dma,
            expected_word(sel, idx));
  endtask

  // one address per cycle, each word checked two cycles later
  task automatic read_all(input logic [1:0] sel);
    for (int t = 0; t < n_coeff + 2; t++) begin
      @(posedge clk);
      if (t < n_coeff) begin
        dma_bram_en <= 1'b1;
        dma_bram_byte_wea <= '0;
        dma_bram_abs_addr <= {sel, 6'(t), 3'b000};
      end else begin
        dma_bram_en <= 1'b0;
      end
      @(negedge clk);
      if (t >= 2) begin
        compare($sformatf("doutb_dma (sel %0d, idx %0d)", sel, t - 2), doutb_dma,
                expected_word(sel, 6'(t - 2)));
      end
    end
  endtask

  task automatic write_command(input logic [7:0] cmd);
    @(posedge clk);
    command_in <= cmd;
    command_we <= 1'b1;
    @(posedge clk);
    command_we <= 1'b0;
    pwm_on = (cmd[poly_core_pkg::opcode_w-1:0] == poly_core_pkg::op_pwm);
  endtask

  task automatic wait_done(input logic level, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (done !== level && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (done !== level) begin
      fail_run($sformatf("timed out after %0d cycles waiting for %s", limit, what));
    end
  endtask

  initial begin
    int order [2*n_coeff];
    int pick;
    int tmp;
    logic [1:0] sel;
    logic [5:0] idx;
    logic [63:0] data;

    void'($urandom(9345));
    rst = 1'b1;
    command_in = '0;
    command_we = 1'b0;
    dma_bram_en = 1'b0;
    dma_bram_byte_wea = '0;
    dma_bram_abs_addr = '0;
    dina_dma = '0;
    pwm_on = 1'b0;
    load_golden();

    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    compare("done", 64'(done), 64'd0);

    // load both polynomials in shuffled order
    for (int i = 0; i < 2 * n_coeff; i++) begin
      order[i] = i;
    end
    for (int i = 2 * n_coeff - 1; i > 0; i--) begin
      pick = int'($urandom % 32'(i + 1));
      tmp = order[i];
      order[i] = order[pick];
      order[pick] = tmp;
    end
    for (int i = 0; i < 2 * n_coeff; i++) begin
      sel = 2'(order[i] / n_coeff);
      idx = 6'(order[i] % n_coeff);
      // junk above the coefficient must not come back
      data = {$urandom, $urandom};
      data[poly_core_pkg::coeff_w-1:0] = (sel == 2'd0) ? msg_gold[idx] : key_gold[idx];
      dma_access(sel, idx, 8'hff, data);
    end
    read_all(2'd0);
    read_all(2'd1);

    // partial byte enables and unmapped selects leave both banks alone
    dma_access(2'd0, 6'd5, 8'h7f, 64'h1555);
    dma_access(2'd1, 6'd9, 8'hfe, 64'h0aaa);
    dma_access(2'd2, 6'd5, 8'hff, 64'h0777);
    read_check(2'd0, 6'd5);
    read_check(2'd1, 6'd9);
    read_check(2'd2, 6'd5);
    read_check(2'd3, 6'd63);

    write_command(8'(poly_core_pkg::op_pwm));
    dma_access(2'd0, 6'd3, 8'hff, 64'h0123);
    wait_done(1'b1, 400, "done to rise after op_pwm");
    for (int i = 0; i < n_coeff; i++) begin
      msg_model[i] = prod_gold[i];
    end
    dma_access(2'd0, 6'd10, 8'hff, 64'h0bad);
    dma_access(2'd1, 6'd11, 8'hff, 64'h0bee);
    @(negedge clk);
    compare("done", 64'(done), 64'd1);
    read_all(2'd0);
    read_all(2'd1);

    write_command(8'(poly_core_pkg::op_nop));
    wait_done(1'b0, 20, "done to fall after op_nop");
    read_all(2'd0);

    $display("All checks passed");
    $finish;
  end

endmodule

// File: dv/pwm_golden.txt
# columns: message key expected, all hex, one coefficient per line in index order
# expected is message times key modulo 12289
0013 3000 2fee
00d3 1801 186a
0193 0002 0326
0253 0003 06f9
0313 3000 2cee
03d3 1801 19ea
0493 0002 0926
0553 0003 0ff9
0613 3000 29ee
06d3 1801 1b6a
0793 0002 0f26
0853 0003 18f9
0913 3000 26ee
09d3 1801 1cea
0a93 0002 1526
0b53 0003 21f9
0c13 3000 23ee
0cd3 1801 1e6a
0d93 0002 1b26
0e53 0003 2af9
0f13 3000 20ee
0fd3 1801 1fea
1093 0002 2126
1153 0003 03f8
1213 3000 1dee
12d3 1801 216a
1393 0002 2726
1453 0003 0cf8
1513 3000 1aee
15d3 1801 22ea
1693 0002 2d26
1753 0003 15f8
1813 3000 17ee
18d3 1801 246a
1993 0002 0325
1a53 0003 1ef8
1b13 3000 14ee
1bd3 1801 25ea
1c93 0002 0925
1d53 0003 27f8
1e13 3000 11ee
1ed3 1801 276a
1f93 0002 0f25
2053 0003 00f7
2113 3000 0eee
21d3 1801 28ea
2293 0002 1525
2353 0003 09f7
2413 3000 0bee
24d3 1801 2a6a
2593 0002 1b25
2653 0003 12f7
2713 3000 08ee
27d3 1801 2bea
2893 0002 2125
2953 0003 1bf7
2a13 3000 05ee
2ad3 1801 2d6a
2b93 0002 2725
2c53 0003 24f7
2d13 3000 02ee
2dd3 1801 2eea
2e93 0002 2d25
2f53 0003 2df7

// File: dv/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int half_period = 10
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  // free-running clock, 20 ns period by default
  initial begin
    clk = 1'b0;
    forever begin
      #(half_period) clk = ~clk;
    end
  end

endmodule

// File: hdl/barrett_reduce.sv
module barrett_reduce (
  input  logic                                clk,
  input  logic [2*poly_core_pkg::coeff_w-1:0] product,
  output logic [poly_core_pkg::coeff_w-1:0]   result
);

  logic [2*poly_core_pkg::coeff_w+poly_core_pkg::barrett_mu_w-1:0] prod_mu;
  logic [poly_core_pkg::barrett_mu_w-1:0] quot_est;
  logic [2*poly_core_pkg::coeff_w-1:0] prod_q;
  logic [2*poly_core_pkg::coeff_w-1:0] diff;
  logic [poly_core_pkg::coeff_w:0] rem;
  logic [poly_core_pkg::coeff_w:0] rem_sub;

  // quotient estimate floor(x * mu / 2^k)
  assign prod_mu = product * poly_core_pkg::barrett_mu;

  always_ff @(posedge clk) begin
    quot_est <= prod_mu[2*poly_core_pkg::coeff_w+poly_core_pkg::barrett_mu_w-1:
                        poly_core_pkg::barrett_k];
    prod_q <= product;
  end

  // estimate is at most one short, so the remainder stays below 2q
  assign diff = prod_q - quot_est * poly_core_pkg::q_mod;
  assign rem = diff[poly_core_pkg::coeff_w:0];
  assign rem_sub = rem - {1'b0, poly_core_pkg::q_mod};

  always_ff @(posedge clk) begin
    if (rem >= {1'b0, poly_core_pkg::q_mod}) begin
      result <= rem_sub[poly_core_pkg::coeff_w-1:0];
    end else begin
      result <= rem[poly_core_pkg::coeff_w-1:0];
    end
  end

endmodule

// File: hdl/compute_core.sv
module compute_core (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [poly_core_pkg::cmd_w-1:0]      command_in,
  input  logic                                 command_we,
  input  logic                                 dma_bram_en,
  input  logic [poly_core_pkg::dma_be_w-1:0]   dma_bram_byte_wea,
  input  logic [poly_core_pkg::dma_addr_w-1:0] dma_bram_abs_addr,
  input  logic [poly_core_pkg::dma_word_w-1:0] dina_dma,
  output logic [poly_core_pkg::dma_word_w-1:0] doutb_dma,
  output logic                                 done
);

  logic [poly_core_pkg::cmd_w-1:0] command_reg;
  poly_core_pkg::opcode_e opcode;
  logic pwm_active;
  logic pwm_rst;
  logic pwm_done;
  logic pwm_busy;

  poly_core_pkg::dma_bram_e dma_sel;
  logic [poly_core_pkg::logn-1:0] dma_idx;
  logic dma_wr;
  logic msg_dma_wea;
  logic key_dma_wea;
  poly_core_pkg::dma_bram_e dma_sel_pipe [poly_core_pkg::bram_rd_lat];
  poly_core_pkg::dma_bram_e dma_sel_d;

  logic [poly_core_pkg::logn-1:0] pwm_a_rd_addr;
  logic [poly_core_pkg::logn-1:0] pwm_b_rd_addr;
  logic [poly_core_pkg::logn-1:0] pwm_wr_addr;
  logic [poly_core_pkg::coeff_w-1:0] pwm_wr_data;
  logic pwm_wea;

  logic [poly_core_pkg::logn-1:0] msg_wr_addr;
  logic [poly_core_pkg::coeff_w-1:0] msg_wr_data;
  logic msg_wea;
  logic [poly_core_pkg::logn-1:0] msg_rd_addr;
  logic [poly_core_pkg::logn-1:0] key_rd_addr;
  logic [poly_core_pkg::coeff_w-1:0] msg_rd_data;
  logic [poly_core_pkg::coeff_w-1:0] key_rd_data;

  // command register, cleared to op_nop
  always_ff @(posedge clk) begin
    if (rst) begin
      command_reg <= '0;
    end else if (command_we) begin
      command_reg <= command_in;
    end
  end

  assign opcode = poly_core_pkg::opcode_e'(command_reg[poly_core_pkg::opcode_w-1:0]);
  assign pwm_active = (opcode == poly_core_pkg::op_pwm);
  assign pwm_rst = rst || !pwm_active;
  // read port returns to DMA once the products are written
  assign pwm_busy = pwm_active && !pwm_done;
  assign done = pwm_done;

  // absolute address split into memory select and coefficient index
  assign dma_sel = poly_core_pkg::dma_bram_e'(
                   dma_bram_abs_addr[poly_core_pkg::dma_sel_lsb +: poly_core_pkg::dma_sel_w]);
  assign dma_idx = dma_bram_abs_addr[poly_core_pkg::dma_idx_lsb +: poly_core_pkg::logn];

  // only full-word writes count, and none while the multiply owns the banks
  assign dma_wr = dma_bram_en && (&dma_bram_byte_wea) && !pwm_active;
  assign msg_dma_wea = dma_wr && (dma_sel == poly_core_pkg::dma_msg);
  assign key_dma_wea = dma_wr && (dma_sel == poly_core_pkg::dma_key);

  assign msg_wr_addr = pwm_active ? pwm_wr_addr : dma_idx;
  assign msg_wr_data = pwm_active ? pwm_wr_data : dina_dma[poly_core_pkg::coeff_w-1:0];
  assign msg_wea = pwm_active ? pwm_wea : msg_dma_wea;

  assign msg_rd_addr = pwm_busy ? pwm_a_rd_addr : dma_idx;
  assign key_rd_addr = pwm_busy ? pwm_b_rd_addr : dma_idx;

  poly_bank_pair u_msg_bank (
    .clk     (clk),
    .wr_addr (msg_wr_addr),
    .wr_data (msg_wr_data),
    .wea     (msg_wea),
    .rd_addr (msg_rd_addr),
    .rd_data (msg_rd_data)
  );

  poly_bank_pair u_key_bank (
    .clk     (clk),
    .wr_addr (dma_idx),
    .wr_data (dina_dma[poly_core_pkg::coeff_w-1:0]),
    .wea     (key_dma_wea),
    .rd_addr (key_rd_addr),
    .rd_data (key_rd_data)
  );

  pwm_unit u_pwm (
    .clk       (clk),
    .rst       (pwm_rst),
    .a_rd_addr (pwm_a_rd_addr),
    .a_rd_data (msg_rd_data),
    .b_rd_addr (pwm_b_rd_addr),
    .b_rd_data (key_rd_data),
    .wr_addr   (pwm_wr_addr),
    .wr_data   (pwm_wr_data),
    .wea       (pwm_wea),
    .done      (pwm_done)
  );

  // select follows the read data through the bank latency
  always_ff @(posedge clk) begin
    dma_sel_pipe[0] <= dma_sel;
    for (int i = 1; i < poly_core_pkg::bram_rd_lat; i++) begin
      dma_sel_pipe[i] <= dma_sel_pipe[i-1];
    end
  end

  assign dma_sel_d = dma_sel_pipe[poly_core_pkg::bram_rd_lat-1];

  always_comb begin
    case (dma_sel_d)
      poly_core_pkg::dma_msg: begin
        doutb_dma = {{(poly_core_pkg::dma_word_w-poly_core_pkg::coeff_w){1'b0}}, msg_rd_data};
      end
      poly_core_pkg::dma_key: begin
        doutb_dma = {{(poly_core_pkg::dma_word_w-poly_core_pkg::coeff_w){1'b0}}, key_rd_data};
      end
      // unmapped selects read as zero
      default: begin
        doutb_dma = '0;
      end
    endcase
  end

endmodule

// File: hdl/poly_bank_pair.sv
module poly_bank_pair (
  input  logic                              clk,
  input  logic [poly_core_pkg::logn-1:0]    wr_addr,
  input  logic [poly_core_pkg::coeff_w-1:0] wr_data,
  input  logic                              wea,
  input  logic [poly_core_pkg::logn-1:0]    rd_addr,
  output logic [poly_core_pkg::coeff_w-1:0] rd_data
);

  // even coefficients in bank0, odd ones in bank1
  logic [poly_core_pkg::coeff_w-1:0] bank0 [poly_core_pkg::bank_depth];
  logic [poly_core_pkg::coeff_w-1:0] bank1 [poly_core_pkg::bank_depth];

  logic [poly_core_pkg::coeff_w-1:0] rd_pipe0 [poly_core_pkg::bram_rd_lat];
  logic [poly_core_pkg::coeff_w-1:0] rd_pipe1 [poly_core_pkg::bram_rd_lat];
  logic [poly_core_pkg::bram_rd_lat-1:0] sel_pipe;

  logic [poly_core_pkg::logn-2:0] wr_row;
  logic [poly_core_pkg::logn-2:0] rd_row;

  assign wr_row = wr_addr[poly_core_pkg::logn-1:1];
  assign rd_row = rd_addr[poly_core_pkg::logn-1:1];

  always_ff @(posedge clk) begin
    if (wea && !wr_addr[0]) begin
      bank0[wr_row] <= wr_data;
    end
    if (wea && wr_addr[0]) begin
      bank1[wr_row] <= wr_data;
    end
  end

  // both banks read every cycle, bank select travels with the data
  always_ff @(posedge clk) begin
    rd_pipe0[0] <= bank0[rd_row];
    rd_pipe1[0] <= bank1[rd_row];
    sel_pipe[0] <= rd_addr[0];
    for (int i = 1; i < poly_core_pkg::bram_rd_lat; i++) begin
      rd_pipe0[i] <= rd_pipe0[i-1];
      rd_pipe1[i] <= rd_pipe1[i-1];
      sel_pipe[i] <= sel_pipe[i-1];
    end
  end

  assign rd_data = sel_pipe[poly_core_pkg::bram_rd_lat-1] ?
                   rd_pipe1[poly_core_pkg::bram_rd_lat-1] :
                   rd_pipe0[poly_core_pkg::bram_rd_lat-1];

endmodule

// File: hdl/poly_core_pkg.sv
package poly_core_pkg;

  // polynomial shape
  localparam int n_coeff = 64;
  localparam int logn = 6;
  localparam int coeff_w = 14;
  localparam int bank_depth = n_coeff / 2;
  localparam logic [logn-1:0] last_idx = logn'(n_coeff - 1);

  // fixed modulus and Barrett constants, mu = floor(2^28 / 12289)
  localparam logic [coeff_w-1:0] q_mod = 14'd12289;
  localparam int barrett_k = 28;
  localparam int barrett_mu_w = 15;
  localparam logic [barrett_mu_w-1:0] barrett_mu = 15'd21843;

  // memory timing
  localparam int bram_rd_lat = 2;
  // read latency plus product register plus two reduction stages
  localparam int pwm_pipe_lat = bram_rd_lat + 3;

  // DMA port and absolute address layout
  localparam int dma_word_w = 64;
  localparam int dma_be_w = dma_word_w / 8;
  localparam int dma_addr_w = 11;
  localparam int dma_sel_w = 2;
  localparam int dma_sel_lsb = 9;
  localparam int dma_idx_lsb = 3;

  localparam int cmd_w = 8;
  localparam int opcode_w = 3;

  typedef enum logic [opcode_w-1:0] {
    op_nop = 3'd0,
    op_pwm = 3'd4
  } opcode_e;

  typedef enum logic [dma_sel_w-1:0] {
    dma_msg = 2'd0,
    dma_key = 2'd1
  } dma_bram_e;

  typedef enum logic [1:0] {
    idle,
    run,
    drain,
    finished
  } pwm_state_e;

endpackage

// File: hdl/pwm_unit.sv
module pwm_unit (
  input  logic                              clk,
  input  logic                              rst,
  output logic [poly_core_pkg::logn-1:0]    a_rd_addr,
  input  logic [poly_core_pkg::coeff_w-1:0] a_rd_data,
  output logic [poly_core_pkg::logn-1:0]    b_rd_addr,
  input  logic [poly_core_pkg::coeff_w-1:0] b_rd_data,
  output logic [poly_core_pkg::logn-1:0]    wr_addr,
  output logic [poly_core_pkg::coeff_w-1:0] wr_data,
  output logic                              wea,
  output logic                              done
);

  poly_core_pkg::pwm_state_e state;
  logic [poly_core_pkg::logn-1:0] rd_idx;
  logic issue;
  logic last_write;

  // valid and index follow each coefficient through read, multiply, reduce
  logic [poly_core_pkg::pwm_pipe_lat-1:0] vld_sr;
  logic [poly_core_pkg::logn-1:0] idx_sr [poly_core_pkg::pwm_pipe_lat];
  logic [2*poly_core_pkg::coeff_w-1:0] prod_q;

  assign issue = (state == poly_core_pkg::run);
  assign a_rd_addr = rd_idx;
  assign b_rd_addr = rd_idx;

  assign wea = vld_sr[poly_core_pkg::pwm_pipe_lat-1];
  assign wr_addr = idx_sr[poly_core_pkg::pwm_pipe_lat-1];
  assign last_write = wea && (wr_addr == poly_core_pkg::last_idx);
  assign done = (state == poly_core_pkg::finished);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= poly_core_pkg::idle;
      rd_idx <= '0;
    end else begin
      case (state)
        poly_core_pkg::idle: begin
          state <= poly_core_pkg::run;
        end
        poly_core_pkg::run: begin
          rd_idx <= rd_idx + 1'b1;
          if (rd_idx == poly_core_pkg::last_idx) begin
            state <= poly_core_pkg::drain;
          end
        end
        poly_core_pkg::drain: begin
          // wait for the last coefficient to leave the reducer
          if (last_write) begin
            state <= poly_core_pkg::finished;
          end
        end
        default: begin
          state <= poly_core_pkg::finished;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[poly_core_pkg::pwm_pipe_lat-2:0], issue};
    end
  end

  always_ff @(posedge clk) begin
    idx_sr[0] <= rd_idx;
    for (int i = 1; i < poly_core_pkg::pwm_pipe_lat; i++) begin
      idx_sr[i] <= idx_sr[i-1];
    end
    prod_q <= a_rd_data * b_rd_data;
  end

  barrett_reduce u_reduce (
    .clk     (clk),
    .product (prod_q),
    .result  (wr_data)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module compute_core_tb -f tb.f -o compute_core_sim &&
./obj_dir/compute_core_sim |
  awk '{ print } /All checks passed/ { found = 1 } END { exit !found }' &&
echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb.f
hdl/poly_core_pkg.sv
hdl/poly_bank_pair.sv
hdl/barrett_reduce.sv
hdl/pwm_unit.sv
hdl/compute_core.sv
dv/tb_clock_gen.sv
dv/compute_core_checker.sv
dv/compute_core_tb.sv
